//--- Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f all.f
	./obj_dir/Vconv_tb +verilator+error+limit+1000 > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- all.f
common/conv_geom_pkg.sv
common/conv_ctrl_pkg.sv
conv_controller/conv_controller.sv
verilog/conv_mac_engine.sv
verilog/conv_result_store.sv
verilog/conv_accel_top.sv
testbench/conv_properties.sv
testbench/conv_clock_gen.sv
testbench/conv_checker.sv
testbench/conv_tb.sv

//--- common/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

  // Sequencer states
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_COMPUTE = 2'd1;
  localparam logic [1:0] ST_STORE   = 2'd2;
  localparam logic [1:0] ST_FINISH  = 2'd3;

  // Chunk count from the host and the running counter
  localparam int NCHUNK_W = 16;

  // Index handed to the datapath, same width as the datapath expects
  localparam int SEQ_IDX_W = conv_geom_pkg::CHUNK_IDX_W;

endpackage

//--- common/conv_geom_pkg.sv
package conv_geom_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////////////////////

  // Samples and taps share one width
  localparam int SAMPLE_W = 16;

  // Four 32-bit products summed need two guard bits, rounded up to 36
  localparam int ACC_W    = 36;
  localparam int RESULT_W = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Memory geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int MEM_DEPTH = 256;
  localparam int ADDR_W    = 8;

  // Kernel length
  localparam int TAPS      = 4;
  localparam int TAP_IDX_W = 2;

  // Outputs per chunk, and chunk index into the result memory
  localparam int CHUNK_LEN   = 8;
  localparam int CHUNK_IDX_W = 5;

endpackage

//--- conv_controller/conv_controller.sv
`timescale 1ns/1ps

module conv_controller
  import conv_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [NCHUNK_W-1:0]  n_chunks,
  input  logic                 conv_start,
  input  logic                 compute_done,
  input  logic                 store_done,
  output logic                 compute_req,
  output logic                 store_req,
  output logic [SEQ_IDX_W-1:0] chunk_index,
  output logic                 conv_done
);

  logic [1:0]          state;
  logic [1:0]          next_state;
  logic [NCHUNK_W-1:0] count;
  logic [NCHUNK_W-1:0] next_count;
  logic                next_compute_req;
  logic                next_store_req;
  logic                next_conv_done;

  // Counter runs 1..n, the datapath wants 0-based
  assign chunk_index = SEQ_IDX_W'(count - 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // State and strobe registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= ST_IDLE;
      count       <= '0;
      compute_req <= 1'b0;
      store_req   <= 1'b0;
      conv_done   <= 1'b0;
    end
    else
    begin
      state       <= next_state;
      count       <= next_count;
      compute_req <= next_compute_req;
      store_req   <= next_store_req;
      conv_done   <= next_conv_done;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next_state       = state;
    next_count       = count;
    next_compute_req = 1'b0;
    next_store_req   = 1'b0;
    next_conv_done   = 1'b0;
    case (state)
      ST_IDLE:
      begin
        next_count = '0;
        if (conv_start)
        begin
          next_state       = ST_COMPUTE;
          next_count       = NCHUNK_W'(1);
          next_compute_req = 1'b1;
        end
      end
      ST_COMPUTE:
      begin
        if (compute_done)
        begin
          next_state     = ST_STORE;
          next_store_req = 1'b1;
        end
      end
      ST_STORE:
      begin
        // First chunk always runs, so a count of 0 acts as 1
        if (store_done)
        begin
          if (count < n_chunks)
          begin
            next_state       = ST_COMPUTE;
            next_count       = count + 1'b1;
            next_compute_req = 1'b1;
          end
          else
          begin
            next_state     = ST_FINISH;
            next_conv_done = 1'b1;
          end
        end
      end
      default:
      begin
        next_state = ST_IDLE;
        next_count = '0;
      end
    endcase
  end

endmodule

//--- testbench/conv_checker.sv
`timescale 1ns/1ps

module conv_checker
  import conv_geom_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                conv_done,
  input  logic [ADDR_W-1:0]   result_addr,
  input  logic [RESULT_W-1:0] result_data,
  input  logic                check_en,
  input  logic [RESULT_W-1:0] exp_data,
  input  int                  test_id,
  output int                  check_count,
  output int                  error_count,
  output int                  done_count
);

  // Request seen on the read port, answered one cycle later
  logic                pend_en;
  logic [ADDR_W-1:0]   pend_addr;
  logic [RESULT_W-1:0] pend_exp;
  int                  pend_id;

  function automatic string test_name(input int id);
    case (id)
      1:       return "single_chunk";
      2:       return "multi_chunk";
      3:       return "wraparound";
      4:       return "extreme_values";
      5:       return "run_control";
      6:       return "back_to_back";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge clk)
  begin
    pend_en   <= check_en && !reset;
    pend_addr <= result_addr;
    pend_exp  <= exp_data;
    pend_id   <= test_id;
  end

  // Compare mid-cycle, where the registered read data is settled
  always @(negedge clk)
  begin
    if (pend_en)
    begin
      check_count = check_count + 1;
      if (result_data !== pend_exp)
      begin
        error_count = error_count + 1;
        $display("FAILED %s addr %0d expected 0x%08h actual 0x%08h",
                 test_name(pend_id), pend_addr, pend_exp, result_data);
      end
    end
    if (!reset && conv_done)
      done_count = done_count + 1;
  end

endmodule

//--- testbench/conv_clock_gen.sv
`timescale 1ns/1ps

module conv_clock_gen
(
  output logic clk,
  output logic reset
);

  // 4 ns period
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held for 8 rising edges, released just after the last one
  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

//--- testbench/conv_properties.sv
`timescale 1ns/1ps

module conv_properties
  import conv_ctrl_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       compute_req,
  input logic       store_req,
  input logic       conv_done,
  input logic [1:0] state
);

  // Failed assertions, read by the testbench at the end of the run
  int fail_count;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer strobes
  ////////////////////////////////////////////////////////////////////////////

  req_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(compute_req && store_req))
  else
  begin
    $error("compute_req and store_req are high in the same cycle");
    fail_count = fail_count + 1;
  end

  compute_req_pulse: assert property (@(posedge clk) disable iff (reset)
    compute_req |=> !compute_req)
  else
  begin
    $error("compute_req stayed high for more than one cycle");
    fail_count = fail_count + 1;
  end

  store_req_pulse: assert property (@(posedge clk) disable iff (reset)
    store_req |=> !store_req)
  else
  begin
    $error("store_req stayed high for more than one cycle");
    fail_count = fail_count + 1;
  end

  done_pulse: assert property (@(posedge clk) disable iff (reset)
    conv_done |=> !conv_done)
  else
  begin
    $error("conv_done stayed high for more than one cycle");
    fail_count = fail_count + 1;
  end

  // Sequencer is back in idle the cycle after the finish pulse
  done_then_idle: assert property (@(posedge clk) disable iff (reset)
    conv_done |=> (state == ST_IDLE))
  else
  begin
    $error("sequencer did not return to idle after conv_done");
    fail_count = fail_count + 1;
  end

endmodule

bind conv_controller conv_properties i_conv_properties (
  .clk         (clk),
  .reset       (reset),
  .compute_req (compute_req),
  .store_req   (store_req),
  .conv_done   (conv_done),
  .state       (state)
);

//--- testbench/conv_tb.sv
`timescale 1ns/1ps

module conv_tb
  import conv_geom_pkg::*;
  import conv_ctrl_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 4000;

  logic                       clk;
  logic                       reset;
  logic                       sample_we;
  logic [ADDR_W-1:0]          sample_addr;
  logic signed [SAMPLE_W-1:0] sample_data;
  logic                       coef_we;
  logic [TAP_IDX_W-1:0]       coef_idx;
  logic signed [SAMPLE_W-1:0] coef_data;
  logic [NCHUNK_W-1:0]        n_chunks;
  logic                       conv_start;
  logic                       conv_done;
  logic [ADDR_W-1:0]          result_addr;
  logic [RESULT_W-1:0]        result_data;

  logic                       check_en;
  logic [RESULT_W-1:0]        exp_data;
  int                         test_id;
  int                         check_count;
  int                         error_count;
  int                         done_count;

  // Reference model
  logic signed [SAMPLE_W-1:0] model_samples [MEM_DEPTH];
  logic signed [SAMPLE_W-1:0] model_taps [TAPS];
  logic [RESULT_W-1:0]        model_result [MEM_DEPTH];
  bit                         written [MEM_DEPTH];

  int                         other_errors;
  int                         starts_accepted;
  bit                         timed_out;
  int                         seed_val;

  conv_clock_gen i_conv_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  conv_accel_top i_conv_accel_top (
    .clk         (clk),
    .reset       (reset),
    .sample_we   (sample_we),
    .sample_addr (sample_addr),
    .sample_data (sample_data),
    .coef_we     (coef_we),
    .coef_idx    (coef_idx),
    .coef_data   (coef_data),
    .n_chunks    (n_chunks),
    .conv_start  (conv_start),
    .conv_done   (conv_done),
    .result_addr (result_addr),
    .result_data (result_data)
  );

  conv_checker i_conv_checker (
    .clk         (clk),
    .reset       (reset),
    .conv_done   (conv_done),
    .result_addr (result_addr),
    .result_data (result_data),
    .check_en    (check_en),
    .exp_data    (exp_data),
    .test_id     (test_id),
    .check_count (check_count),
    .error_count (error_count),
    .done_count  (done_count)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic signed [SAMPLE_W-1:0] pick_value(input bit extreme);
    if (extreme)
      return ($urandom_range(1, 0) == 1) ? 16'sh7fff : 16'sh8000;
    return SAMPLE_W'($urandom);
  endfunction

  task automatic load_samples(input bit extreme);
    logic signed [SAMPLE_W-1:0] v;
    for (int a = 0; a < MEM_DEPTH; a++)
    begin
      v = pick_value(extreme);
      model_samples[a] = v;
      @(posedge clk);
      #1;
      sample_we   = 1'b1;
      sample_addr = ADDR_W'(a);
      sample_data = v;
    end
    @(posedge clk);
    #1;
    sample_we = 1'b0;
  endtask

  task automatic load_taps(input bit extreme);
    logic signed [SAMPLE_W-1:0] v;
    for (int t = 0; t < TAPS; t++)
    begin
      v = pick_value(extreme);
      model_taps[t] = v;
      @(posedge clk);
      #1;
      coef_we   = 1'b1;
      coef_idx  = TAP_IDX_W'(t);
      coef_data = v;
    end
    @(posedge clk);
    #1;
    coef_we = 1'b0;
  endtask

  // Output j = sum of tap[t] * sample[(j+t) mod 256], low 32 bits kept
  task automatic update_model(input int n);
    int     chunks;
    longint sum;
    chunks = (n == 0) ? 1 : n;
    for (int j = 0; j < chunks * CHUNK_LEN; j++)
    begin
      sum = 0;
      for (int t = 0; t < TAPS; t++)
        sum = sum + longint'(model_taps[t]) * longint'(model_samples[(j + t) % MEM_DEPTH]);
      model_result[j] = sum[RESULT_W-1:0];
      written[j]      = 1'b1;
    end
  endtask

  task automatic run_conv(input int n, input bit stray_start);
    int cycles;
    bit seen;
    if (timed_out)
      return;
    @(posedge clk);
    #1;
    n_chunks   = NCHUNK_W'(n);
    conv_start = 1'b1;
    @(posedge clk);
    #1;
    conv_start = 1'b0;
    starts_accepted = starts_accepted + 1;
    // A second start while the first chunk is still computing
    if (stray_start)
    begin
      repeat (3) @(posedge clk);
      #1;
      conv_start = 1'b1;
      @(posedge clk);
      #1;
      conv_start = 1'b0;
    end
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      #1;
      if (conv_done)
        seen = 1'b1;
      cycles = cycles + 1;
    end
    if (!seen)
    begin
      $display("Timeout: conv_done did not arrive within %0d cycles", TIMEOUT_CYCLES);
      other_errors = other_errors + 1;
      timed_out    = 1'b1;
      return;
    end
    update_model(n);
    // Let the sequencer get back to idle
    repeat (3) @(posedge clk);
  endtask

  task automatic read_back(input int id);
    if (timed_out)
      return;
    test_id = id;
    for (int a = 0; a < MEM_DEPTH; a++)
    begin
      if (written[a])
      begin
        @(posedge clk);
        #1;
        result_addr = ADDR_W'(a);
        exp_data    = model_result[a];
        check_en    = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    check_en = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic check_done_count();
    if (done_count != starts_accepted)
    begin
      $display("conv_done was seen %0d times but %0d starts were accepted",
               done_count, starts_accepted);
      other_errors = other_errors + 1;
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (reset && cycles < 100)
    begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
    end
    if (reset)
    begin
      $display("Timeout: reset was never released");
      other_errors = other_errors + 1;
      timed_out    = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int assert_fails;
    seed_val    = $urandom(32'h99bb7329);
    sample_we   = 1'b0;
    sample_addr = '0;
    sample_data = '0;
    coef_we     = 1'b0;
    coef_idx    = '0;
    coef_data   = '0;
    n_chunks    = '0;
    conv_start  = 1'b0;
    result_addr = '0;
    check_en    = 1'b0;
    exp_data    = '0;
    test_id     = 0;

    wait_reset_release();

    load_samples(1'b0);
    load_taps(1'b0);
    run_conv(1, 1'b0);
    read_back(1);

    load_taps(1'b0);
    run_conv(int'($urandom_range(32, 2)), 1'b0);
    read_back(2);

    // Last outputs of chunk 31 reach back to samples 0..2
    load_samples(1'b0);
    run_conv(32, 1'b0);
    read_back(3);

    load_samples(1'b1);
    load_taps(1'b1);
    run_conv(32, 1'b0);
    read_back(4);

    // Count of 0 runs chunk 0 only, stray start ignored
    load_taps(1'b0);
    run_conv(0, 1'b1);
    check_done_count();
    read_back(5);

    load_taps(1'b0);
    run_conv(int'($urandom_range(32, 2)), 1'b0);
    read_back(6);
    check_done_count();

    repeat (2) @(posedge clk);
    assert_fails = i_conv_accel_top.i_conv_controller.i_conv_properties.fail_count;
    $display("Checks: %0d, data errors: %0d, assertion failures: %0d, other errors: %0d",
             check_count, error_count, assert_fails, other_errors);
    if (error_count + assert_fails + other_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- verilog/conv_accel_top.sv
`timescale 1ns/1ps

module conv_accel_top
  import conv_geom_pkg::*;
  import conv_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       sample_we,
  input  logic [ADDR_W-1:0]          sample_addr,
  input  logic signed [SAMPLE_W-1:0] sample_data,
  input  logic                       coef_we,
  input  logic [TAP_IDX_W-1:0]       coef_idx,
  input  logic signed [SAMPLE_W-1:0] coef_data,
  input  logic [NCHUNK_W-1:0]        n_chunks,
  input  logic                       conv_start,
  output logic                       conv_done,
  input  logic [ADDR_W-1:0]          result_addr,
  output logic [RESULT_W-1:0]        result_data
);

  logic                         compute_req;
  logic                         compute_done;
  logic                         store_req;
  logic                         store_done;
  logic [CHUNK_IDX_W-1:0]       chunk_index;
  logic [$clog2(CHUNK_LEN)-1:0] buf_addr;
  logic [RESULT_W-1:0]          buf_data;

  conv_controller i_conv_controller (
    .clk          (clk),
    .reset        (reset),
    .n_chunks     (n_chunks),
    .conv_start   (conv_start),
    .compute_done (compute_done),
    .store_done   (store_done),
    .compute_req  (compute_req),
    .store_req    (store_req),
    .chunk_index  (chunk_index),
    .conv_done    (conv_done)
  );

  conv_mac_engine i_conv_mac_engine (
    .clk          (clk),
    .reset        (reset),
    .sample_we    (sample_we),
    .sample_addr  (sample_addr),
    .sample_data  (sample_data),
    .coef_we      (coef_we),
    .coef_idx     (coef_idx),
    .coef_data    (coef_data),
    .compute_req  (compute_req),
    .chunk_index  (chunk_index),
    .buf_addr     (buf_addr),
    .buf_data     (buf_data),
    .compute_done (compute_done)
  );

  conv_result_store i_conv_result_store (
    .clk          (clk),
    .reset        (reset),
    .store_req    (store_req),
    .chunk_index  (chunk_index),
    .buf_addr     (buf_addr),
    .buf_data     (buf_data),
    .result_addr  (result_addr),
    .result_data  (result_data),
    .store_done   (store_done)
  );

endmodule

//--- verilog/conv_mac_engine.sv
`timescale 1ns/1ps

module conv_mac_engine
  import conv_geom_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         sample_we,
  input  logic [ADDR_W-1:0]            sample_addr,
  input  logic signed [SAMPLE_W-1:0]   sample_data,
  input  logic                         coef_we,
  input  logic [TAP_IDX_W-1:0]         coef_idx,
  input  logic signed [SAMPLE_W-1:0]   coef_data,
  input  logic                         compute_req,
  input  logic [CHUNK_IDX_W-1:0]       chunk_index,
  input  logic [$clog2(CHUNK_LEN)-1:0] buf_addr,
  output logic [RESULT_W-1:0]          buf_data,
  output logic                         compute_done
);

  logic signed [SAMPLE_W-1:0] sample_mem [MEM_DEPTH];
  logic signed [SAMPLE_W-1:0] taps [TAPS];
  logic [RESULT_W-1:0]        chunk_buf [CHUNK_LEN];

  // Issue counters
  logic                         running;
  logic [$clog2(CHUNK_LEN)-1:0] out_idx;
  logic [TAP_IDX_W-1:0]         tap_idx;
  logic [ADDR_W-1:0]            base;

  // Address stage
  logic                         a_valid;
  logic                         a_first;
  logic                         a_last;
  logic [ADDR_W-1:0]            a_addr;
  logic [TAP_IDX_W-1:0]         a_tap;
  logic [$clog2(CHUNK_LEN)-1:0] a_out;

  // Read stage
  logic                         r_valid;
  logic                         r_first;
  logic                         r_last;
  logic signed [SAMPLE_W-1:0]   r_sample;
  logic signed [SAMPLE_W-1:0]   r_coef;
  logic [$clog2(CHUNK_LEN)-1:0] r_out;

  // Multiply stage
  logic                         m_valid;
  logic                         m_first;
  logic                         m_last;
  logic signed [2*SAMPLE_W-1:0] m_prod;
  logic [$clog2(CHUNK_LEN)-1:0] m_out;

  logic signed [ACC_W-1:0]      prod_ext;
  logic signed [ACC_W-1:0]      acc;
  logic signed [ACC_W-1:0]      acc_next;

  assign buf_data = chunk_buf[buf_addr];

  ////////////////////////////////////////////////////////////////////////////
  // Host writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (sample_we)
      sample_mem[sample_addr] <= sample_data;
    if (coef_we)
      taps[coef_idx] <= coef_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control: issue counters and valid chain
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      running      <= 1'b0;
      out_idx      <= '0;
      tap_idx      <= '0;
      a_valid      <= 1'b0;
      r_valid      <= 1'b0;
      m_valid      <= 1'b0;
      compute_done <= 1'b0;
    end
    else
    begin
      if (compute_req && !running)
      begin
        running <= 1'b1;
        out_idx <= '0;
        tap_idx <= '0;
      end
      else if (running)
      begin
        tap_idx <= tap_idx + 1'b1;
        if (tap_idx == '1)
          out_idx <= out_idx + 1'b1;
        if (tap_idx == '1 && out_idx == '1)
          running <= 1'b0;
      end
      a_valid      <= running;
      r_valid      <= a_valid;
      m_valid      <= r_valid;
      compute_done <= m_valid && m_last && (m_out == '1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (compute_req && !running)
      base <= ADDR_W'({chunk_index, {$clog2(CHUNK_LEN){1'b0}}});

    // Sample index wraps modulo the memory depth
    a_addr  <= base + ADDR_W'(out_idx) + ADDR_W'(tap_idx);
    a_tap   <= tap_idx;
    a_out   <= out_idx;
    a_first <= (tap_idx == '0);
    a_last  <= (tap_idx == '1);

    r_sample <= sample_mem[a_addr];
    r_coef   <= taps[a_tap];
    r_out    <= a_out;
    r_first  <= a_first;
    r_last   <= a_last;

    m_prod  <= r_sample * r_coef;
    m_out   <= r_out;
    m_first <= r_first;
    m_last  <= r_last;

    if (m_valid)
    begin
      acc <= acc_next;
      if (m_last)
        chunk_buf[m_out] <= acc_next[RESULT_W-1:0];
    end
  end

  // Sign extension to the accumulator width
  assign prod_ext = m_prod;
  assign acc_next = m_first ? prod_ext : acc + prod_ext;

endmodule

//--- verilog/conv_result_store.sv
`timescale 1ns/1ps

module conv_result_store
  import conv_geom_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         store_req,
  input  logic [CHUNK_IDX_W-1:0]       chunk_index,
  output logic [$clog2(CHUNK_LEN)-1:0] buf_addr,
  input  logic [RESULT_W-1:0]          buf_data,
  input  logic [ADDR_W-1:0]            result_addr,
  output logic [RESULT_W-1:0]          result_data,
  output logic                         store_done
);

  logic [RESULT_W-1:0]          result_mem [MEM_DEPTH];
  logic                         active;
  logic [$clog2(CHUNK_LEN)-1:0] word_idx;
  logic [CHUNK_IDX_W-1:0]       chunk_sel;

  // Engine buffer is read combinationally
  assign buf_addr = word_idx;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      active     <= 1'b0;
      word_idx   <= '0;
      store_done <= 1'b0;
    end
    else
    begin
      store_done <= active && (word_idx == '1);
      if (store_req && !active)
      begin
        active   <= 1'b1;
        word_idx <= '0;
      end
      else if (active)
      begin
        word_idx <= word_idx + 1'b1;
        if (word_idx == '1)
          active <= 1'b0;
      end
    end
  end

  // Chunk base is chunk_index times 8
  always_ff @(posedge clk)
  begin
    if (store_req && !active)
      chunk_sel <= chunk_index;
    if (active)
      result_mem[{chunk_sel, word_idx}] <= buf_data;
    result_data <= result_mem[result_addr];
  end

endmodule
